/* dmem_unit.f */
design/dmem_pkg.sv
design/mmio_pkg.sv
design/lane_if.sv
design/lane_ram.sv
design/byte_align.sv
design/write_port_fsm.sv
design/cycle_timer.sv
design/mmio_port.sv
design/dmem_unit.sv
test/dmem_unit_tb.sv

/* Bender.yml */
package:
  name: dmem_unit

sources:
  - design/dmem_pkg.sv
  - design/mmio_pkg.sv
  - design/lane_if.sv
  - design/lane_ram.sv
  - design/byte_align.sv
  - design/write_port_fsm.sv
  - design/cycle_timer.sv
  - design/mmio_port.sv
  - design/dmem_unit.sv
  - target: test
    files:
      - test/dmem_unit_tb.sv

/* test/dmem_unit_tb.sv */
`timescale 1ns/1ps

module dmem_unit_tb;
   import dmem_pkg::*;
   import mmio_pkg::*;

   localparam int DEPTH     = 8;
   localparam int ACK_LIMIT = 64;    // cycles allowed for each loader wait

   logic       clk, arst_n, run, we, mem_to_reg, reg_we_in, unsigned_load, load_req;
   logic       reg_we_out, uart_we, fifo_in_re, fifo_out_we, load_ack;
   word_t      addr, wdata, alu_result, fifo_in_data, fifo_in_count, load_addr, load_data;
   word_t      reg_wdata, uart_data, fifo_out_data, tcount, lcg_state;
   logic [4:0] rd_in, reg_rd;
   size_e      size;
   logic [7:0] mem_model [2**DEPTH];    // byte image of the four banks
   string      test_name;

   dmem_unit #(.DEPTH(DEPTH)) i_dmem_unit (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic word_t lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic check_word(input string what, input word_t exp, input word_t act);
      if (act !== exp) begin
         $display("Error %s %s: expected %h, actual %h", test_name, what, exp, act);
         $display("TEST FAILED");
         $fatal(1, "word mismatch");
      end
   endtask

   task automatic check_flag(input string what, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Error %s %s: expected %b, actual %b", test_name, what, exp, act);
         $display("TEST FAILED");
         $fatal(1, "flag mismatch");
      end
   endtask

   task automatic check_rd(input string what, input logic [4:0] exp, input logic [4:0] act);
      if (act !== exp) begin
         $display("Error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
         $display("TEST FAILED");
         $fatal(1, "register index mismatch");
      end
   endtask

   task automatic abort_on_timeout(input string what);
      $display("timeout in %s: %s", test_name, what);
      $display("TEST FAILED");
      $fatal(1, "wait limit reached");
   endtask

   task automatic write_bytes(input logic [7:0] a, input word_t d, input size_e sz);
      int n;
      n = (sz == SZ_BYTE) ? 1 : ((sz == SZ_HALF) ? 2 : 4);
      for (int i = 0; i < n; i++) begin
         mem_model[a + i] = d[8*i +: 8];    // little endian
      end
   endtask

   task automatic random_op();
      word_t r;
      r             = lcg_next();
      run           = (r[3:0] != 4'd0);
      reg_we_in     = r[4];
      rd_in         = r[9:5];
      unsigned_load = r[10];
      size          = size_e'(r[12:11]);
      we            = r[15:13] inside {3'd1, 3'd2, 3'd3};
      mem_to_reg    = r[15:13] inside {3'd4, 3'd5, 3'd6};
      addr          = {24'd0, r[23:16]};
      if (size == SZ_HALF) addr[0] = 1'b0;
      else if (size != SZ_BYTE) addr[1:0] = 2'b00;
      wdata         = lcg_next();
      alu_result    = lcg_next();
      fifo_in_data  = lcg_next();
      fifo_in_count = lcg_next();
      if (we || mem_to_reg) test_name = "ram_round_trip";
      else test_name = "pass_through";
      if (r[15:13] == 3'd7) begin    // register map access
         size       = SZ_WORD;
         we         = r[27];
         mem_to_reg = ~r[27];
         if (r[27]) test_name = "mmio_write";
         else test_name = "mmio_read";
         case (r[26:24])
            3'd0: addr = UART_ADDR;
            3'd1: addr = FIFO_OUT_ADDR;
            3'd2: addr = FIFO_IN_ADDR;
            3'd3: addr = FIFO_CNT_ADDR;
            default: addr = TIMER_ADDR;
         endcase
      end
   endtask

   // pipeline traffic that keeps clear of the loader's word
   task automatic op_beside_loader(input logic full);
      random_op();
      test_name  = "loader";
      mem_to_reg = 1'b0;
      size       = SZ_WORD;
      addr       = {24'd0, alu_result[7:2], 2'b00};
      if (addr[7:2] == load_addr[7:2]) addr[2] = ~addr[2];
      if (full) begin
         run = 1'b1;
         we  = 1'b1;
      end
   endtask

   task automatic apply_op();
      word_t      exp_wdata;
      word_t      lw;
      logic [7:0] a;
      logic       is_map, exp_we, exp_uart, exp_fout, exp_fin;
      a        = addr[7:0];
      is_map   = addr inside {UART_ADDR, FIFO_IN_ADDR, FIFO_CNT_ADDR, FIFO_OUT_ADDR, TIMER_ADDR};
      exp_we   = run & reg_we_in;
      exp_uart = run & we & (addr == UART_ADDR);
      exp_fout = run & we & (addr == FIFO_OUT_ADDR);
      exp_fin  = run & mem_to_reg & (addr == FIFO_IN_ADDR);
      lw       = {mem_model[a + 8'd3], mem_model[a + 8'd2], mem_model[a + 8'd1], mem_model[a]};
      if (!mem_to_reg) exp_wdata = alu_result;
      else if (addr == FIFO_CNT_ADDR) exp_wdata = fifo_in_count;
      else if (addr == FIFO_IN_ADDR) exp_wdata = fifo_in_data;
      else if (addr == TIMER_ADDR) exp_wdata = tcount;    // count during the load cycle
      else if (size == SZ_BYTE) exp_wdata = {{24{~unsigned_load & lw[7]}}, lw[7:0]};
      else if (size == SZ_HALF) exp_wdata = {{16{~unsigned_load & lw[15]}}, lw[15:0]};
      else exp_wdata = lw;
      if (run && we && !is_map) write_bytes(a, wdata, size);
      if (run && we && addr == TIMER_ADDR) tcount = '0;
      else if (run) tcount = tcount + 1;
      @(negedge clk);
      check_rd("reg_rd", rd_in, reg_rd);
      check_flag("reg_we_out", exp_we, reg_we_out);
      check_word("reg_wdata", exp_wdata, reg_wdata);
      check_flag("uart_we", exp_uart, uart_we);
      check_flag("fifo_out_we", exp_fout, fifo_out_we);
      check_flag("fifo_in_re", exp_fin, fifo_in_re);
      if (exp_uart) check_word("uart_data", wdata, uart_data);
      if (exp_fout) check_word("fifo_out_data", wdata, fifo_out_data);
   endtask

   task automatic run_loader();
      word_t r;
      int    cycles;
      r         = lcg_next();
      load_addr = {24'd0, r[7:2], 2'b00};
      load_data = lcg_next();
      load_req  = 1'b1;
      repeat (4) begin
         op_beside_loader(1'b1);
         apply_op();
         check_flag("load_ack", 1'b0, load_ack);    // port held by stores
      end
      cycles = 0;
      while (load_ack !== 1'b1) begin
         if (cycles == ACK_LIMIT) abort_on_timeout("load_ack never rose");
         op_beside_loader(1'b0);
         apply_op();
         cycles++;
      end
      write_bytes(load_addr[7:0], load_data, SZ_WORD);
      load_req = 1'b0;
      cycles   = 0;
      while (load_ack !== 1'b0) begin
         if (cycles == ACK_LIMIT) abort_on_timeout("load_ack stayed high after load_req fell");
         op_beside_loader(1'b0);
         apply_op();
         cycles++;
      end
      op_beside_loader(1'b0);
      run        = 1'b1;
      we         = 1'b0;
      mem_to_reg = 1'b1;
      addr       = load_addr;    // read back the loaded word
      apply_op();
   endtask

   initial begin
      lcg_state     = 32'h3ebb_a7cc;
      arst_n        = 1'b0;
      run           = 1'b0;
      we            = 1'b0;
      mem_to_reg    = 1'b0;
      reg_we_in     = 1'b0;
      unsigned_load = 1'b0;
      load_req      = 1'b0;
      addr          = '0;
      size          = SZ_WORD;
      wdata         = '0;
      alu_result    = '0;
      rd_in         = '0;
      fifo_in_data  = '0;
      fifo_in_count = '0;
      load_addr     = '0;
      load_data     = '0;
      tcount        = '0;
      test_name     = "reset";
      repeat (5) @(posedge clk);
      @(negedge clk);
      check_flag("reg_we_out", 1'b0, reg_we_out);
      check_flag("uart_we", 1'b0, uart_we);
      check_flag("fifo_out_we", 1'b0, fifo_out_we);
      check_flag("fifo_in_re", 1'b0, fifo_in_re);
      check_flag("load_ack", 1'b0, load_ack);
      arst_n = 1'b1;
      for (int i = 0; i < 2**DEPTH; i += 4) begin
         random_op();
         test_name  = "ram_fill";
         run        = 1'b1;
         we         = 1'b1;
         mem_to_reg = 1'b0;
         size       = SZ_WORD;
         addr       = i;
         apply_op();
      end
      repeat (600) begin
         random_op();
         apply_op();
      end
      repeat (8) run_loader();
      $display("TEST OK");
      $finish;
   end

endmodule

/* design/dmem_unit.sv */
`timescale 1ns/1ps

module dmem_unit #(
   parameter int DEPTH = 12
) (
   input  logic            clk,
   input  logic            arst_n,
   input  logic            run,
   input  dmem_pkg::word_t addr,
   input  dmem_pkg::size_e size,
   input  dmem_pkg::word_t wdata,
   input  logic            we,
   input  logic            mem_to_reg,
   input  dmem_pkg::word_t alu_result,
   input  logic [4:0]      rd_in,
   input  logic            reg_we_in,
   input  logic            unsigned_load,
   output dmem_pkg::word_t reg_wdata,
   output logic            reg_we_out,
   output logic [4:0]      reg_rd,
   output dmem_pkg::word_t uart_data,
   output logic            uart_we,
   input  dmem_pkg::word_t fifo_in_data,
   input  dmem_pkg::word_t fifo_in_count,
   output logic            fifo_in_re,
   output dmem_pkg::word_t fifo_out_data,
   output logic            fifo_out_we,
   input  logic            load_req,
   input  dmem_pkg::word_t load_addr,
   input  dmem_pkg::word_t load_data,
   output logic            load_ack
);

   dmem_pkg::word_t st_data;
   dmem_pkg::be_t   st_be;
   dmem_pkg::word_t ld_data;
   dmem_pkg::word_t count;
   logic            ram_store;
   logic            clear;

   lane_if #(.AW(DEPTH-2)) lanes ();

   lane_ram #(.DEPTH(DEPTH), .LANE(0)) i_lane_ram_0 (.clk(clk), .lanes(lanes));
   lane_ram #(.DEPTH(DEPTH), .LANE(1)) i_lane_ram_1 (.clk(clk), .lanes(lanes));
   lane_ram #(.DEPTH(DEPTH), .LANE(2)) i_lane_ram_2 (.clk(clk), .lanes(lanes));
   lane_ram #(.DEPTH(DEPTH), .LANE(3)) i_lane_ram_3 (.clk(clk), .lanes(lanes));

   byte_align #(.DEPTH(DEPTH)) i_byte_align (
      .clk           (clk),
      .run           (run),
      .we            (we),
      .mem_to_reg    (mem_to_reg),
      .addr          (addr),
      .size          (size),
      .wdata         (wdata),
      .unsigned_load (unsigned_load),
      .st_data       (st_data),
      .st_be         (st_be),
      .ld_data       (ld_data),
      .lanes         (lanes)
   );

   write_port_fsm #(.DEPTH(DEPTH)) i_write_port_fsm (
      .clk       (clk),
      .arst_n    (arst_n),
      .run       (run),
      .we        (we),
      .ram_store (ram_store),
      .word_idx  (addr[DEPTH-1:2]),
      .st_data   (st_data),
      .st_be     (st_be),
      .load_req  (load_req),
      .load_addr (load_addr),
      .load_data (load_data),
      .load_ack  (load_ack),
      .lanes     (lanes)
   );

   cycle_timer i_cycle_timer (
      .clk    (clk),
      .arst_n (arst_n),
      .run    (run),
      .clear  (clear),
      .count  (count)
   );

   mmio_port i_mmio_port (
      .clk           (clk),
      .arst_n        (arst_n),
      .run           (run),
      .we            (we),
      .mem_to_reg    (mem_to_reg),
      .reg_we_in     (reg_we_in),
      .addr          (addr),
      .st_data       (st_data),
      .alu_result    (alu_result),
      .ld_data       (ld_data),
      .count         (count),
      .fifo_in_data  (fifo_in_data),
      .fifo_in_count (fifo_in_count),
      .rd_in         (rd_in),
      .ram_store     (ram_store),
      .clear         (clear),
      .reg_wdata     (reg_wdata),
      .reg_we_out    (reg_we_out),
      .reg_rd        (reg_rd),
      .uart_data     (uart_data),
      .fifo_out_data (fifo_out_data),
      .uart_we       (uart_we),
      .fifo_out_we   (fifo_out_we),
      .fifo_in_re    (fifo_in_re)
   );

endmodule

/* design/mmio_port.sv */
`timescale 1ns/1ps

module mmio_port (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 run,
   input  logic                 we,
   input  logic                 mem_to_reg,
   input  logic                 reg_we_in,
   input  dmem_pkg::dmem_addr_u addr,
   input  dmem_pkg::word_t      st_data,
   input  dmem_pkg::word_t      alu_result,
   input  dmem_pkg::word_t      ld_data,
   input  dmem_pkg::word_t      count,
   input  dmem_pkg::word_t      fifo_in_data,
   input  dmem_pkg::word_t      fifo_in_count,
   input  logic [4:0]           rd_in,
   output logic                 ram_store,
   output logic                 clear,
   output dmem_pkg::word_t      reg_wdata,
   output logic                 reg_we_out,
   output logic [4:0]           reg_rd,
   output dmem_pkg::word_t      uart_data,
   output dmem_pkg::word_t      fifo_out_data,
   output logic                 uart_we,
   output logic                 fifo_out_we,
   output logic                 fifo_in_re
);
   import dmem_pkg::*;
   import mmio_pkg::*;

   logic  hit_uart, hit_fifo_in, hit_fifo_cnt, hit_fifo_out, hit_timer;
   logic  m2r_q, fifo_cnt_q, fifo_in_q, timer_q;
   word_t alu_q, count_q;

   assign hit_uart     = (addr.raw == UART_ADDR);
   assign hit_fifo_in  = (addr.raw == FIFO_IN_ADDR);
   assign hit_fifo_cnt = (addr.raw == FIFO_CNT_ADDR);
   assign hit_fifo_out = (addr.raw == FIFO_OUT_ADDR);
   assign hit_timer    = (addr.raw == TIMER_ADDR);

   assign ram_store = we & ~(hit_uart | hit_fifo_in | hit_fifo_cnt | hit_fifo_out | hit_timer);
   assign clear     = run & we & hit_timer;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         reg_we_out  <= 1'b0;
         uart_we     <= 1'b0;
         fifo_out_we <= 1'b0;
         fifo_in_re  <= 1'b0;
      end else begin
         reg_we_out  <= run & reg_we_in;
         uart_we     <= run & we & hit_uart;
         fifo_out_we <= run & we & hit_fifo_out;
         fifo_in_re  <= run & mem_to_reg & hit_fifo_in;   // pop after the read
      end
   end

   always_ff @(posedge clk) begin
      reg_rd     <= rd_in;
      m2r_q      <= mem_to_reg;
      alu_q      <= alu_result;
      count_q    <= count;    // value seen in the load cycle
      fifo_cnt_q <= hit_fifo_cnt;
      fifo_in_q  <= hit_fifo_in;
      timer_q    <= hit_timer;
      if (run && we && hit_uart) begin
         uart_data <= st_data;
      end
      if (run && we && hit_fifo_out) begin
         fifo_out_data <= st_data;
      end
   end

   always_comb begin
      if (!m2r_q) begin
         reg_wdata = alu_q;
      end else if (fifo_cnt_q) begin
         reg_wdata = fifo_in_count;
      end else if (fifo_in_q) begin
         reg_wdata = fifo_in_data;
      end else if (timer_q) begin
         reg_wdata = count_q;
      end else begin
         reg_wdata = ld_data;
      end
   end

   one_access : assert property (@(posedge clk) disable iff (!arst_n)
      run && we |-> !mem_to_reg)
      else $error("load and store requested in the same cycle");

endmodule

/* design/cycle_timer.sv */
`timescale 1ns/1ps

module cycle_timer (
   input  logic            clk,
   input  logic            arst_n,
   input  logic            run,
   input  logic            clear,
   output dmem_pkg::word_t count
);
   import dmem_pkg::*;

   word_t cnt_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cnt_q <= '0;
      end else if (clear) begin
         cnt_q <= '0;    // store to the timer wins over counting
      end else if (run) begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   assign count = cnt_q;

endmodule

/* design/write_port_fsm.sv */
`timescale 1ns/1ps

module write_port_fsm #(
   parameter int DEPTH = 12
) (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 run,
   input  logic                 we,
   input  logic                 ram_store,
   input  logic [DEPTH-3:0]     word_idx,
   input  dmem_pkg::word_t      st_data,
   input  dmem_pkg::be_t        st_be,
   input  logic                 load_req,
   input  dmem_pkg::dmem_addr_u load_addr,
   input  dmem_pkg::word_t      load_data,
   output logic                 load_ack,
   lane_if.writer               lanes
);
   import dmem_pkg::*;

   localparam logic [1:0] S_IDLE     = 2'd0;
   localparam logic [1:0] S_WRITE    = 2'd1;
   localparam logic [1:0] S_ACK_WAIT = 2'd2;

   logic [1:0] state, state_nxt;
   logic       pipe_wr;

   assign pipe_wr = run & we & ram_store;   // pipeline always wins the port

   always_comb begin
      state_nxt = state;
      case (state)
         S_IDLE: begin
            if (load_req) state_nxt = S_WRITE;
         end
         S_WRITE: begin
            if (!pipe_wr) state_nxt = S_ACK_WAIT;   // loader word goes in this cycle
         end
         S_ACK_WAIT: begin
            if (!load_req) state_nxt = S_IDLE;
         end
         default: state_nxt = S_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= S_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   assign load_ack = (state == S_ACK_WAIT);

   always_comb begin
      lanes.waddr = word_idx;
      lanes.wdata = st_data;
      lanes.wbe   = '0;
      if (pipe_wr) begin
         lanes.wbe = st_be;
      end else if (state == S_WRITE) begin
         lanes.waddr = load_addr.ram.word_idx[DEPTH-3:0];
         lanes.wdata = load_data;
         lanes.wbe   = {BE_W{1'b1}};
      end
   end

   ack_needs_req : assert property (@(posedge clk) disable iff (!arst_n)
      load_ack |-> $past(load_req))
      else $error("load_ack raised without a loader request");

endmodule

/* design/byte_align.sv */
`timescale 1ns/1ps

module byte_align #(
   parameter int DEPTH = 12
) (
   input  logic                 clk,
   input  logic                 run,
   input  logic                 we,
   input  logic                 mem_to_reg,
   input  dmem_pkg::dmem_addr_u addr,
   input  dmem_pkg::size_e      size,
   input  dmem_pkg::word_t      wdata,
   input  logic                 unsigned_load,
   output dmem_pkg::word_t      st_data,
   output dmem_pkg::be_t        st_be,
   output dmem_pkg::word_t      ld_data,
   lane_if.reader               lanes
);
   import dmem_pkg::*;

   be_t        be_base;
   logic [1:0] off_q;
   size_e      size_q;
   logic       sext_q;
   word_t      shifted;

   // store side
   always_comb begin
      case (size)
         SZ_BYTE: be_base = 4'b0001;
         SZ_HALF: be_base = 4'b0011;
         SZ_WORD, SZ_WORD_ALT: be_base = 4'b1111;
         default: be_base = 4'b1111;
      endcase
   end

   assign st_data = wdata << {addr.ram.offset, 3'b000};
   assign st_be   = be_base << addr.ram.offset;

   assign lanes.raddr = addr.ram.word_idx[DEPTH-3:0];

   // follow the bank read latency
   always_ff @(posedge clk) begin
      off_q  <= addr.ram.offset;
      size_q <= size;
      sext_q <= ~unsigned_load;
   end

   assign shifted = lanes.rdata >> {off_q, 3'b000};

   always_comb begin
      case (size_q)
         SZ_BYTE: ld_data = {{24{sext_q & shifted[7]}}, shifted[7:0]};
         SZ_HALF: ld_data = {{16{sext_q & shifted[15]}}, shifted[15:0]};
         default: ld_data = shifted;
      endcase
   end

   word_aligned : assert property (@(posedge clk)
      run && (we || mem_to_reg) && (size inside {SZ_WORD, SZ_WORD_ALT})
      |-> addr.ram.offset == 2'b00)
      else $error("misaligned word access at %h", addr.raw);

   half_aligned : assert property (@(posedge clk)
      run && (we || mem_to_reg) && size == SZ_HALF |-> !addr.ram.offset[0])
      else $error("misaligned halfword access at %h", addr.raw);

endmodule

/* design/lane_ram.sv */
`timescale 1ns/1ps

module lane_ram #(
   parameter int DEPTH = 12,
   parameter int LANE  = 0
) (
   input logic  clk,
   lane_if.bank lanes
);

   logic [7:0] mem [2**(DEPTH-2)];
   logic [7:0] rd_q;

   always_ff @(posedge clk) begin
      if (lanes.wbe[LANE]) begin
         mem[lanes.waddr] <= lanes.wdata[8*LANE +: 8];
      end
      rd_q <= mem[lanes.raddr];   // read before write on a collision
   end

   assign lanes.rdata[8*LANE +: 8] = rd_q;

endmodule

/* design/lane_if.sv */
`timescale 1ns/1ps

interface lane_if #(
   parameter int AW = 10
) ();
   import dmem_pkg::*;

   logic [AW-1:0] waddr;
   word_t         wdata;
   be_t           wbe;
   logic [AW-1:0] raddr;
   wire word_t    rdata;    // each bank drives its own byte

   modport writer (output waddr, wdata, wbe);
   modport reader (output raddr, input rdata);
   modport bank   (input waddr, wdata, wbe, raddr, output rdata);

endinterface

/* design/mmio_pkg.sv */
package mmio_pkg;

   // full 32-bit compare, no partial decode
   localparam logic [31:0] UART_ADDR     = 32'h1000_0000;
   localparam logic [31:0] FIFO_IN_ADDR  = 32'hF000_0000;
   localparam logic [31:0] FIFO_CNT_ADDR = 32'hF000_0004;
   localparam logic [31:0] FIFO_OUT_ADDR = 32'hF000_0008;
   localparam logic [31:0] TIMER_ADDR    = 32'hF000_000C;

endpackage

/* design/dmem_pkg.sv */
package dmem_pkg;

   localparam int WORD_W = 32;
   localparam int BE_W   = WORD_W / 8;
   localparam int IDX_W  = 14;    // word index room for up to 64 KiB of RAM

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [BE_W-1:0]   be_t;

   // access size, code 3 decodes as a word
   typedef enum logic [1:0] {
      SZ_WORD     = 2'd0,
      SZ_BYTE     = 2'd1,
      SZ_HALF     = 2'd2,
      SZ_WORD_ALT = 2'd3
   } size_e;

   typedef struct packed {
      logic [WORD_W-IDX_W-3:0] upper;
      logic [IDX_W-1:0]        word_idx;
      logic [1:0]              offset;     // byte within the word
   } ram_addr_t;

   // raw view for the register map, split view for the RAM banks
   typedef union packed {
      word_t     raw;
      ram_addr_t ram;
   } dmem_addr_u;

endpackage
